// ==== design/accelCommandPort.sv ====
`timescale 1ns/10ps

module accelCommandPort import fftDecodePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     instrValid,
    input  ctrlT     ctrl,
    input  logic     blockInstruction,
    input  logic     accelAck,
    output logic     accelReq,
    output accelCmdT accelCmd,
    output logic     portBusy,
    output logic     portAccepted
);

    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stRelease
    } portStateT;

    portStateT state;
    accelCmdT  nextCmd;
    logic      accept;

    // Map the decoded accelerator flag to a command
    always_comb begin
        if (ctrl.startI) begin
            nextCmd = cmdStartInverse;
        end else if (ctrl.startF) begin
            nextCmd = cmdStartForward;
        end else if (ctrl.loadF) begin
            nextCmd = cmdLoadFilter;
        end else begin
            nextCmd = cmdNone;
        end
    end

    assign accept   = instrValid && (nextCmd != cmdNone) && !blockInstruction &&
                      (state == stIdle);
    assign portBusy = (state != stIdle);

    // Four-phase handshake, one command in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= stIdle;
            accelReq     <= 1'b0;
            accelCmd     <= cmdNone;
            portAccepted <= 1'b0;
        end else begin
            portAccepted <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        state        <= stRequest;
                        accelReq     <= 1'b1;
                        accelCmd     <= nextCmd;
                        portAccepted <= 1'b1;
                    end
                end
                stRequest: begin
                    if (accelAck) begin
                        state    <= stRelease;
                        accelReq <= 1'b0;
                    end
                end
                stRelease: begin
                    // Wait for the accelerator to drop ack
                    if (!accelAck) begin
                        state    <= stIdle;
                        accelCmd <= cmdNone;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    cmdStableDuringReq: assert property (
        @(posedge clk) disable iff (reset)
        ($past(accelReq) && accelReq) |-> $stable(accelCmd)
    ) else $error("accelCommandPort: accelCmd changed while accelReq high");

    noReqWhileAck: assert property (
        @(posedge clk) disable iff (reset)
        $rose(accelReq) |-> !$past(accelAck)
    ) else $error("accelCommandPort: accelReq raised while accelAck still high");

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit import fftDecodePkg::*; (
    input  opcodeT opcode,
    input  logic   fftCalculating,
    input  logic   portBusy,
    output ctrlT   ctrl,
    output logic   blockInstruction
);

    logic accelOp;

    // Per-opcode control table, everything not named stays low
    always_comb begin
        ctrl = '0;
        case (opcode)
            opHalt: begin
                ctrl.halt = 1'b1;
            end
            opNop: begin
                ctrl.nop = 1'b1;
            end
            opAdd: begin
                ctrl.aluOp    = aluAdd;
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSub: begin
                ctrl.aluOp    = aluSub;
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opAddi: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1     = 1'b1;
                ctrl.aluOp        = aluAdd;
                ctrl.regWrite     = 1'b1;
            end
            opSubi: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1     = 1'b1;
                ctrl.aluOp        = aluSub;
                ctrl.regWrite     = 1'b1;
            end
            opLoad: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1     = 1'b1;
                ctrl.memRead      = 1'b1;
                ctrl.memToReg     = 1'b1;
                ctrl.regWrite     = 1'b1;
            end
            opStore: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1     = 1'b1;
                ctrl.memWrite     = 1'b1;
            end
            opBranch: begin
                ctrl.isBranch     = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opJump: begin
                ctrl.isJump       = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opJr: begin
                ctrl.isJR         = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opJal: begin
                // Link address goes to r15
                ctrl.isJump       = 1'b1;
                ctrl.isJAL        = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.regWrite     = 1'b1;
            end
            opSlbi: begin
                ctrl.isSLBI   = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluSlbi;
                ctrl.rsWrite  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLoadF: begin
                ctrl.loadF = 1'b1;
            end
            opStartI: begin
                ctrl.startI = 1'b1;
            end
            opStartF: begin
                ctrl.startF = 1'b1;
            end
            opRte: begin
                ctrl.pcIsEPC = 1'b1;
            end
            default: begin
                // Unknown opcodes behave as nop
                ctrl.nop = 1'b1;
            end
        endcase
    end

    // Hold accelerator instructions while the FFT or the port is busy
    assign accelOp          = ctrl.startI | ctrl.startF | ctrl.loadF;
    assign blockInstruction = accelOp & (fftCalculating | portBusy);

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage import fftDecodePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  wordT     instr,
    input  wordT     pcPlus1,
    input  logic     instrValid,
    input  wordT     writebackData,
    input  logic     fftCalculating,
    input  logic     accelAck,
    output wordT     read1Data,
    output wordT     read2Data,
    output ctrlT     ctrl,
    output exceptT   exceptions,
    output logic     blockInstruction,
    output logic     accelReq,
    output accelCmdT accelCmd
);

    opcodeT opcode;
    regIdxT rsIdx;
    regIdxT rtIdx;
    regIdxT rdIdx;
    regIdxT writeSel;
    wordT   writeData;
    logic   regWriteEn;
    logic   portBusy;
    logic   portAccepted;
    logic   filterLoaded;

    // Instruction fields
    assign opcode = opcodeT'(instr[opcodeHi:opcodeLo]);
    assign rsIdx  = instr[rsHi:rsLo];
    assign rtIdx  = instr[rtHi:rtLo];
    assign rdIdx  = instr[rdHi:rdLo];

    // Write-back register: link, rs, rd, then rt
    assign writeSel = ctrl.isJAL   ? linkReg :
                      ctrl.rsWrite ? rsIdx   :
                      ctrl.regDst  ? rdIdx   : rtIdx;

    assign writeData  = ctrl.isJAL ? pcPlus1 : writebackData;
    assign regWriteEn = ctrl.regWrite & instrValid;

    controlUnit controlUnit_i (
        .opcode           (opcode),
        .fftCalculating   (fftCalculating),
        .portBusy         (portBusy),
        .ctrl             (ctrl),
        .blockInstruction (blockInstruction)
    );

    registerFile registerFile_i (
        .clk       (clk),
        .reset     (reset),
        .read1Sel  (rsIdx),
        .read2Sel  (rtIdx),
        .writeSel  (writeSel),
        .writeData (writeData),
        .write     (regWriteEn),
        .read1Data (read1Data),
        .read2Data (read2Data)
    );

    // Command on accelCmd is the one just accepted while portAccepted is high
    filterStatus filterStatus_i (
        .clk          (clk),
        .reset        (reset),
        .portAccepted (portAccepted),
        .acceptedCmd  (accelCmd),
        .filterLoaded (filterLoaded)
    );

    exceptionCheck exceptionCheck_i (
        .instr        (instr),
        .filterLoaded (filterLoaded),
        .exceptions   (exceptions)
    );

    accelCommandPort accelCommandPort_i (
        .clk              (clk),
        .reset            (reset),
        .instrValid       (instrValid),
        .ctrl             (ctrl),
        .blockInstruction (blockInstruction),
        .accelAck         (accelAck),
        .accelReq         (accelReq),
        .accelCmd         (accelCmd),
        .portBusy         (portBusy),
        .portAccepted     (portAccepted)
    );

endmodule

// ==== design/exceptionCheck.sv ====
`timescale 1ns/10ps

module exceptionCheck import fftDecodePkg::*; (
    input  wordT   instr,
    input  logic   filterLoaded,
    output exceptT exceptions
);

    logic [2:0] group;
    logic       rrOp;
    logic       immOp;
    logic       filterOp;
    logic       rsBank;
    logic       rtBank;
    logic       rdBank;

    assign group    = instr[opcodeHi -: 3];
    assign rrOp     = (group == rrGroup);
    assign immOp    = (group == immGroup);
    assign filterOp = (instr[opcodeHi:opcodeLo] == opLoadF);

    // Top bit of a register number picks the imaginary bank
    assign rsBank = instr[rsHi];
    assign rtBank = instr[rtHi];
    assign rdBank = instr[rdHi];

    // Mixing real and imaginary sources in register arithmetic
    assign exceptions.complexArithmeticEx = rrOp && (rsBank != rtBank);

    // Result bank differs from source bank
    // The rr case only fires when the sources agree
    assign exceptions.realImagLoadEx =
        (immOp && (rsBank != rtBank)) ||
        (rrOp && (rsBank == rtBank) && (rdBank != rsBank));

    // Filter use before any filter was loaded
    assign exceptions.invalidFilterEx = filterOp && instr[filterUseBit] && !filterLoaded;

endmodule

// ==== design/fftDecodePkg.sv ====
package fftDecodePkg;

    // Register number and data word
    typedef logic [3:0]  regIdxT;
    typedef logic [31:0] wordT;

    // Five-bit opcodes
    // 110xx is the register-register arithmetic group, 010xx the immediate group
    typedef enum logic [4:0] {
        opHalt    = 5'b00000,
        opNop     = 5'b00001,
        opLoadF   = 5'b00010,
        opRte     = 5'b00011,
        opJump    = 5'b00100,
        opJr      = 5'b00101,
        opJal     = 5'b00110,
        opAddi    = 5'b01000,
        opSubi    = 5'b01001,
        opBranch  = 5'b01100,
        opStore   = 5'b10000,
        opLoad    = 5'b10001,
        opSlbi    = 5'b10010,
        opStartI  = 5'b10100,
        opStartF  = 5'b10101,
        opAdd     = 5'b11000,
        opSub     = 5'b11001
    } opcodeT;

    // Instruction field positions
    localparam int opcodeHi     = 31;
    localparam int opcodeLo     = 27;
    localparam int rsHi         = 26;
    localparam int rsLo         = 23;
    localparam int rtHi         = 22;
    localparam int rtLo         = 19;
    localparam int rdHi         = 18;
    localparam int rdLo         = 15;
    localparam int filterUseBit = 8;

    // Opcode groups by their top three bits
    localparam logic [2:0] rrGroup  = 3'b110;
    localparam logic [2:0] immGroup = 3'b010;

    // JAL writes the link address here
    localparam regIdxT linkReg = 4'd15;

    // ALU operations
    localparam logic [3:0] aluAdd  = 4'b0000;
    localparam logic [3:0] aluSub  = 4'b0001;
    localparam logic [3:0] aluSlbi = 4'b0010;

    typedef struct packed {
        logic       aluSrc;
        logic       isSignExtend;
        logic       isIType1;
        logic       isBranch;
        logic       halt;
        logic       nop;
        logic       memWrite;
        logic       memRead;
        logic       memToReg;
        logic       isJR;
        logic       isSLBI;
        logic       isJump;
        logic       isJAL;
        logic       regDst;
        logic       rsWrite;
        logic       regWrite;
        logic       pcIsEPC;
        logic [3:0] aluOp;
        logic       startI;
        logic       startF;
        logic       loadF;
    } ctrlT;

    typedef struct packed {
        logic complexArithmeticEx;
        logic realImagLoadEx;
        logic invalidFilterEx;
    } exceptT;

    // Commands sent to the FFT accelerator
    typedef enum logic [1:0] {
        cmdNone         = 2'b00,
        cmdStartInverse = 2'b01,
        cmdStartForward = 2'b10,
        cmdLoadFilter   = 2'b11
    } accelCmdT;

endpackage

// ==== design/filterStatus.sv ====
`timescale 1ns/10ps

module filterStatus import fftDecodePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     portAccepted,
    input  accelCmdT acceptedCmd,
    output logic     filterLoaded
);

    logic loadSeen;

    // A load-filter transfer has been started by the port
    assign loadSeen = portAccepted && (acceptedCmd == cmdLoadFilter);

    // Sticky once set
    always_ff @(posedge clk) begin
        if (reset) begin
            filterLoaded <= 1'b0;
        end else if (loadSeen) begin
            filterLoaded <= 1'b1;
        end
    end

    // Only reset may clear the flag
    filterStaysLoaded: assert property (
        @(posedge clk)
        (!$past(reset) && $past(filterLoaded)) |-> filterLoaded
    ) else $error("filterStatus: filterLoaded cleared without reset");

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/10ps

module registerFile import fftDecodePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  regIdxT read1Sel,
    input  regIdxT read2Sel,
    input  regIdxT writeSel,
    input  wordT   writeData,
    input  logic   write,
    output wordT   read1Data,
    output wordT   read2Data
);

    localparam int numRegs = 2 ** $bits(regIdxT);

    wordT regs [numRegs];

    // Writes to r0 are dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (writeSel != '0)) begin
            regs[writeSel] <= writeData;
        end
    end

    // r0 reads zero, no bypass of a same-cycle write
    assign read1Data = (read1Sel == '0) ? '0 : regs[read1Sel];
    assign read2Data = (read2Sel == '0) ? '0 : regs[read2Sel];

    // Writeback value must be known whenever it is written
    writeDataKnown: assert property (
        @(posedge clk) disable iff (reset)
        write |-> !$isunknown(writeData)
    ) else $error("registerFile: write with unknown data to r%0d", writeSel);

endmodule

// ==== fftDecode.f ====
design/fftDecodePkg.sv
design/controlUnit.sv
design/registerFile.sv
design/filterStatus.sv
design/exceptionCheck.sv
design/accelCommandPort.sv
design/decodeStage.sv
test/decodeChecker.sv
test/decodeStageTb.sv

// ==== test/decodeChecker.sv ====
`timescale 1ns/10ps

module decodeChecker import fftDecodePkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  wordT         instr,
    input  wordT         pcPlus1,
    input  logic         instrValid,
    input  wordT         writebackData,
    input  logic         fftCalculating,
    input  logic         accelAck,
    input  wordT         read1Data,
    input  wordT         read2Data,
    input  ctrlT         ctrl,
    input  exceptT       exceptions,
    input  logic         blockInstruction,
    input  logic         accelReq,
    input  accelCmdT     accelCmd,
    input  logic [127:0] testName,
    output int           checkCount,
    output int           errorCount
);

    wordT     regModel [16];
    logic     filterModel;
    logic     filterSoon;
    int       phase;
    accelCmdT cmdModel;
    accelCmdT requestedCmd;
    ctrlT     expCtrl;
    exceptT   expEx;
    regIdxT   dest;
    logic     accelOp;
    logic     expBlock;
    logic     accept;

    // Control table of the instruction set
    function automatic ctrlT expectedCtrl(input logic [4:0] code);
        case (code)
            opHalt:   return '{halt: '1, default: '0};
            opNop:    return '{nop: '1, default: '0};
            opAdd:    return '{aluOp: aluAdd, regDst: '1, regWrite: '1, default: '0};
            opSub:    return '{aluOp: aluSub, regDst: '1, regWrite: '1, default: '0};
            opAddi:   return '{aluSrc: '1, isSignExtend: '1, isIType1: '1, aluOp: aluAdd,
                               regWrite: '1, default: '0};
            opSubi:   return '{aluSrc: '1, isSignExtend: '1, isIType1: '1, aluOp: aluSub,
                               regWrite: '1, default: '0};
            opLoad:   return '{aluSrc: '1, isSignExtend: '1, isIType1: '1, memRead: '1,
                               memToReg: '1, regWrite: '1, default: '0};
            opStore:  return '{aluSrc: '1, isSignExtend: '1, isIType1: '1, memWrite: '1,
                               default: '0};
            opBranch: return '{isBranch: '1, isSignExtend: '1, default: '0};
            opJump:   return '{isJump: '1, isSignExtend: '1, default: '0};
            opJr:     return '{isJR: '1, isSignExtend: '1, default: '0};
            opJal:    return '{isJump: '1, isJAL: '1, isSignExtend: '1, regWrite: '1,
                               default: '0};
            opSlbi:   return '{isSLBI: '1, aluSrc: '1, aluOp: aluSlbi, rsWrite: '1,
                               regWrite: '1, default: '0};
            opLoadF:  return '{loadF: '1, default: '0};
            opStartI: return '{startI: '1, default: '0};
            opStartF: return '{startF: '1, default: '0};
            opRte:    return '{pcIsEPC: '1, default: '0};
            default:  return '{nop: '1, default: '0};
        endcase
    endfunction

    // Bank bits are the top bits of rs, rt and rd
    function automatic exceptT expectedExceptions(input wordT w, input logic loaded);
        exceptT e;
        logic   sameSrc;
        sameSrc = (w[26] == w[22]);
        e.complexArithmeticEx = (w[31:29] == 3'b110) && !sameSrc;
        e.realImagLoadEx = ((w[31:29] == 3'b010) && !sameSrc) ||
                           ((w[31:29] == 3'b110) && sameSrc && (w[18] != w[26]));
        e.invalidFilterEx = (w[31:27] == 5'b00010) && w[8] && !loaded;
        return e;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("MISMATCH %0s %0s expected %h actual %h", testName, what, expected,
                     actual);
        end
    endtask

    assign expCtrl  = expectedCtrl(instr[31:27]);
    assign expEx    = expectedExceptions(instr, filterModel);
    assign accelOp  = expCtrl.startI | expCtrl.startF | expCtrl.loadF;
    assign expBlock = accelOp && (fftCalculating || (phase != 0));
    assign accept   = instrValid && accelOp && !expBlock;

    assign dest = expCtrl.isJAL   ? linkReg :
                  expCtrl.rsWrite ? instr[26:23] :
                  expCtrl.regDst  ? instr[18:15] : instr[22:19];

    assign requestedCmd = expCtrl.startI ? cmdStartInverse :
                          expCtrl.startF ? cmdStartForward :
                          expCtrl.loadF  ? cmdLoadFilter : cmdNone;

    initial begin
        checkCount = 0;
        errorCount = 0;
    end

    // Reference model, updated on the same edges as the DUT
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regModel[i] <= '0;
            end
            filterModel <= 1'b0;
            filterSoon  <= 1'b0;
            phase       <= 0;
            cmdModel    <= cmdNone;
        end else begin
            if (expCtrl.regWrite && instrValid && (dest != 4'd0)) begin
                regModel[dest] <= expCtrl.isJAL ? pcPlus1 : writebackData;
            end
            // Filter counts as loaded one edge after the request goes out
            if (filterSoon) begin
                filterModel <= 1'b1;
            end
            filterSoon <= 1'b0;
            case (phase)
                0: begin
                    if (accept) begin
                        phase      <= 1;
                        cmdModel   <= requestedCmd;
                        filterSoon <= expCtrl.loadF;
                    end
                end
                1: begin
                    if (accelAck) begin
                        phase <= 2;
                    end
                end
                default: begin
                    if (!accelAck) begin
                        phase <= 0;
                    end
                end
            endcase
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            compareValue("ctrl", expCtrl, ctrl);
            compareValue("exceptions", expEx, exceptions);
            compareValue("blockInstruction", expBlock, blockInstruction);
            compareValue("read1Data", regModel[instr[26:23]], read1Data);
            compareValue("read2Data", regModel[instr[22:19]], read2Data);
            compareValue("accelReq", phase == 1, accelReq);
            if (phase == 1) begin
                compareValue("accelCmd", cmdModel, accelCmd);
            end
        end
    end

endmodule

// ==== test/decodeStageTb.sv ====
`timescale 1ns/10ps

module decodeStageTb import fftDecodePkg::*; ();

    localparam wordT nopWord   = {opNop, 27'd0};
    localparam int   waitLimit = 20;

    typedef struct packed {
        wordT         instr;
        wordT         pcPlus1;
        wordT         wbData;
        logic         valid;
        logic         fftCalc;
        logic         waitDone;
        logic [127:0] name;
    } entryT;

    logic         clk;
    logic         reset;
    wordT         instr;
    wordT         pcPlus1;
    logic         instrValid;
    wordT         writebackData;
    logic         fftCalculating;
    logic         accelAck;
    wordT         read1Data;
    wordT         read2Data;
    ctrlT         ctrl;
    exceptT       exceptions;
    logic         blockInstruction;
    logic         accelReq;
    accelCmdT     accelCmd;
    logic [127:0] testName;
    int           checkCount;
    int           errorCount;
    int           timeouts;
    logic [31:0]  lfsr;
    logic         ackPending;
    int           ackDelay;
    entryT        stimTable[$];

    decodeStage decodeStage_i (.*);

    decodeChecker decodeChecker_i (.*);

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawDelay(output int cycles);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            lfsr    = lfsrStep(lfsr);
            bits[b] = lfsr[0];
        end
        cycles = int'(bits) + 1;
    endtask

    // Flags are {not valid, filter use bit, fftCalculating, wait for transfer}
    task automatic addEntry(input logic [4:0] op, input regIdxT rs, input regIdxT rt,
                            input regIdxT rd, input logic [3:0] flags, input wordT pc,
                            input wordT wb, input logic [127:0] name);
        entryT e;
        e.instr    = {op, rs, rt, rd, 6'd0, flags[2], 8'd0};
        e.pcPlus1  = pc;
        e.wbData   = wb;
        e.valid    = !flags[3];
        e.fftCalc  = flags[1];
        e.waitDone = flags[0];
        e.name     = name;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        addEntry(opHalt,   4'd0, 4'd0, 4'd0, 4'b0000, 32'h0, 32'h0, "halt");
        addEntry(opNop,    4'd0, 4'd0, 4'd0, 4'b0000, 32'h0, 32'h0, "nop");
        addEntry(5'b11111, 4'd0, 4'd0, 4'd0, 4'b0000, 32'h0, 32'h0, "unknown op");
        addEntry(opAdd,    4'd0, 4'd0, 4'd1, 4'b0000, 32'h0, 32'h1111_1111, "add wr rd1");
        addEntry(opSub,    4'd1, 4'd0, 4'd2, 4'b0000, 32'h0, 32'h2222_2222, "sub wr rd2");
        addEntry(opAddi,   4'd2, 4'd3, 4'd0, 4'b0000, 32'h0, 32'h3333_3333, "addi wr rt3");
        addEntry(opSubi,   4'd3, 4'd4, 4'd0, 4'b0000, 32'h0, 32'h4444_4444, "subi wr rt4");
        addEntry(opLoad,   4'd4, 4'd5, 4'd0, 4'b0000, 32'h0, 32'h5555_5555, "load wr rt5");
        addEntry(opSlbi,   4'd6, 4'd5, 4'd0, 4'b0000, 32'h0, 32'h6666_6666, "slbi wr rs6");
        addEntry(opAdd,    4'd6, 4'd0, 4'd0, 4'b0000, 32'h0, 32'hdead_beef, "add to r0");
        addEntry(opStore,  4'd0, 4'd6, 4'd0, 4'b0000, 32'h0, 32'h0, "store r0 r6");
        addEntry(opJal,    4'd0, 4'd0, 4'd0, 4'b0000, 32'h100, 32'h0bad, "jal link");
        addEntry(opJump,   4'd15, 4'd1, 4'd0, 4'b0000, 32'h0, 32'h0, "jump read r15");
        addEntry(opJr,     4'd2, 4'd3, 4'd0, 4'b0000, 32'h0, 32'h0, "jr");
        addEntry(opBranch, 4'd4, 4'd5, 4'd0, 4'b0000, 32'h0, 32'h0, "branch");
        addEntry(opRte,    4'd0, 4'd0, 4'd0, 4'b0000, 32'h0, 32'h0, "rte");
        // Without instrValid nothing is written
        addEntry(opAdd,    4'd0, 4'd0, 4'd7, 4'b1000, 32'h0, 32'h1234_5678, "add not valid");
        addEntry(opJal,    4'd0, 4'd0, 4'd0, 4'b1000, 32'h200, 32'h0, "jal not valid");
        addEntry(opStore,  4'd7, 4'd15, 4'd0, 4'b0000, 32'h0, 32'h0, "store r7 r15");
        // Bank mixes with rs/rt 8 to 15 in the imaginary bank
        addEntry(opAdd,    4'd8, 4'd1, 4'd2, 4'b0000, 32'h0, 32'h7777_7777, "cplx add");
        addEntry(opSub,    4'd1, 4'd9, 4'd9, 4'b0000, 32'h0, 32'h8888_8888, "cplx prio sub");
        addEntry(opAdd,    4'd9, 4'd10, 4'd3, 4'b0000, 32'h0, 32'h9999_9999, "rimag add");
        addEntry(opAddi,   4'd1, 4'd9, 4'd0, 4'b0000, 32'h0, 32'haaaa_aaaa, "rimag addi");
        addEntry(opAdd,    4'd9, 4'd10, 4'd11, 4'b0000, 32'h0, 32'hbbbb_bbbb, "imag add ok");
        addEntry(opAddi,   4'd9, 4'd10, 4'd0, 4'b0000, 32'h0, 32'hcccc_cccc, "addi ok");
        // Accelerator commands and back-pressure
        addEntry(opLoadF,  4'd0, 4'd0, 4'd0, 4'b0101, 32'h0, 32'h0, "loadf no filt");
        addEntry(opLoadF,  4'd0, 4'd0, 4'd0, 4'b0101, 32'h0, 32'h0, "loadf loaded");
        addEntry(opStartF, 4'd0, 4'd0, 4'd0, 4'b1000, 32'h0, 32'h0, "startf not valid");
        addEntry(opStartF, 4'd0, 4'd0, 4'd0, 4'b0000, 32'h0, 32'h0, "startf");
        addEntry(opStartI, 4'd0, 4'd0, 4'd0, 4'b0001, 32'h0, 32'h0, "starti busy");
        addEntry(opStartI, 4'd0, 4'd0, 4'd0, 4'b0010, 32'h0, 32'h0, "starti fft busy");
        addEntry(opStartI, 4'd0, 4'd0, 4'd0, 4'b0001, 32'h0, 32'h0, "starti");
        addEntry(opLoadF,  4'd0, 4'd0, 4'd0, 4'b0001, 32'h0, 32'h0, "loadf no use");
    endtask

    // Follow one transfer through ack, req fall and ack fall
    task automatic waitTransfer(input logic [127:0] name);
        int n;
        n = 0;
        @(negedge clk);
        while (!accelAck && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!accelAck) begin
            $display("Timeout: accelerator never acknowledged a request in %0s", name);
            timeouts++;
        end
        n = 0;
        while (accelReq && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (accelReq) begin
            $display("Timeout: accelReq stayed high after the acknowledge in %0s", name);
            timeouts++;
        end
        n = 0;
        while (accelAck && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (accelAck) begin
            $display("Timeout: accelAck never dropped, port stays busy in %0s", name);
            timeouts++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Accelerator model answers each req edge after 1 to 4 cycles
    always @(posedge clk) begin
        if (reset) begin
            accelAck   <= 1'b0;
            ackPending = 1'b0;
            ackDelay   = 0;
        end else if (accelReq != accelAck) begin
            if (!ackPending) begin
                drawDelay(ackDelay);
                ackPending = 1'b1;
            end
            ackDelay = ackDelay - 1;
            if (ackDelay == 0) begin
                accelAck   <= accelReq;
                ackPending = 1'b0;
            end
        end
    end

    initial begin
        reset          = 1'b1;
        instr          = nopWord;
        pcPlus1        = '0;
        instrValid     = 1'b0;
        writebackData  = '0;
        fftCalculating = 1'b0;
        accelAck       = 1'b0;
        testName       = "reset";
        timeouts       = 0;
        lfsr           = 32'h5b931cb7;
        buildTable();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (stimTable[i]) begin
            @(posedge clk);
            instr          <= stimTable[i].instr;
            pcPlus1        <= stimTable[i].pcPlus1;
            writebackData  <= stimTable[i].wbData;
            fftCalculating <= stimTable[i].fftCalc;
            instrValid     <= stimTable[i].valid;
            testName       <= stimTable[i].name;
            if (stimTable[i].waitDone) begin
                @(posedge clk);
                instrValid <= 1'b0;
                instr      <= nopWord;
                waitTransfer(stimTable[i].name);
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        instr      <= nopWord;
        repeat (3) @(posedge clk);
        $display("checks=%0d mismatches=%0d timeouts=%0d", checkCount, errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0 && checkCount > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
